//--- rtl/dp_aux_defs.svh
`ifndef DP_AUX_DEFS_SVH
`define DP_AUX_DEFS_SVH

// ==================================================
// bus widths
// ==================================================
`define DP_AUX_ADDR_W 20
`define DP_AUX_BYTE_W 8
`define DP_AUX_CMD_W 2

// request codes, upper nibble of header byte 0
`define DP_AUX_NATIVE_WR 4'b1000
`define DP_AUX_NATIVE_RD 4'b1001

// reply codes, bits 5:4 of the first reply byte
`define DP_AUX_ACK 2'b00
`define DP_AUX_NACK 2'b01
`define DP_AUX_DEFER 2'b10

// ==================================================
// timing
// ==================================================
`define DP_AUX_TIMEOUT_CYCLES 40
`define DP_AUX_MAX_RETRIES 3
`define DP_HPD_CONNECT_CYCLES 16
`define DP_HPD_IRQ_MIN_CYCLES 4
`define DP_HPD_IRQ_MAX_CYCLES 12

`endif

//--- rtl/dp_aux_pkg.sv
`include "dp_aux_defs.svh"

package dp_aux_pkg;

    // basic vectors
    typedef logic [`DP_AUX_BYTE_W-1:0] aux_byte_t;
    typedef logic [`DP_AUX_ADDR_W-1:0] aux_addr_t;
    typedef logic [`DP_AUX_BYTE_W-1:0] aux_len_t;
    typedef logic [`DP_AUX_CMD_W-1:0]  aux_cmd_t;
    typedef logic [1:0]                reply_code_t;

    // one native request from the requester
    typedef struct packed {
        aux_cmd_t  cmd;
        aux_addr_t address;
        aux_len_t  len;
        aux_byte_t data;
    } aux_request_t;

    // decoded reply, ack and data valids are single-cycle strobes
    typedef struct packed {
        reply_code_t ack;
        logic        ack_vld;
        aux_byte_t   data;
        logic        data_vld;
    } aux_reply_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_SEND,
        CTRL_WAIT_REPLY,
        CTRL_RECEIVE
    } ctrl_state_t;

    typedef enum logic [1:0] {
        ENC_IDLE,
        ENC_HEADER,
        ENC_DATA
    } enc_state_t;

    typedef enum logic [1:0] {
        HPD_DISCONNECTED,
        HPD_CONNECTING,
        HPD_CONNECTED,
        HPD_LOW_PULSE
    } hpd_state_t;

endpackage

//--- rtl/reply_decoder.sv
`include "dp_aux_defs.svh"

module reply_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  dp_aux_pkg::aux_byte_t  aux_in,
    input  logic                   aux_in_vld,
    input  logic                   phy_start_stop,
    output dp_aux_pkg::aux_reply_t reply,
    output logic                   reply_start,
    output logic                   reply_end
);

    // reply code is the low half of the upper nibble
    localparam int CODE_LSB = `DP_AUX_BYTE_W - 4;

    logic                    frame_open;
    logic                    is_code;
    logic                    is_data;
    logic                    last_seen;
    logic                    ack_vld;
    logic                    data_vld;
    dp_aux_pkg::reply_code_t ack_code;
    dp_aux_pkg::aux_byte_t   data_q;

    assign is_code = aux_in_vld && phy_start_stop && !frame_open;
    assign is_data = aux_in_vld && frame_open;

    assign reply_start = is_code;
    // a code-only frame ends when the byte stream stops
    assign reply_end   = last_seen || (frame_open && !aux_in_vld);

    assign reply = '{ack: ack_code, ack_vld: ack_vld, data: data_q, data_vld: data_vld};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_open <= 1'b0;
            last_seen  <= 1'b0;
            ack_vld    <= 1'b0;
            data_vld   <= 1'b0;
        end else begin
            ack_vld   <= is_code;
            data_vld  <= is_data;
            last_seen <= is_data && phy_start_stop;
            if (is_code) begin
                frame_open <= 1'b1;
            end else if (!aux_in_vld || phy_start_stop) begin
                frame_open <= 1'b0;
            end
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (is_code) begin
            ack_code <= aux_in[CODE_LSB +: 2];
        end
        if (is_data) begin
            data_q <= aux_in;
        end
    end

endmodule

//--- rtl/hpd_detector.sv
`include "dp_aux_defs.svh"

module hpd_detector (
    input  logic clk,
    input  logic rst_n,
    input  logic hpd_signal,
    output logic hpd_detect,
    output logic hpd_irq
);

    localparam int CNT_MAX = (`DP_HPD_CONNECT_CYCLES > `DP_HPD_IRQ_MAX_CYCLES) ?
                             `DP_HPD_CONNECT_CYCLES : `DP_HPD_IRQ_MAX_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    localparam logic [CNT_W-1:0] CONNECT_LAST = CNT_W'(`DP_HPD_CONNECT_CYCLES - 1);
    localparam logic [CNT_W-1:0] IRQ_MIN      = CNT_W'(`DP_HPD_IRQ_MIN_CYCLES);
    localparam logic [CNT_W-1:0] IRQ_MAX      = CNT_W'(`DP_HPD_IRQ_MAX_CYCLES);

    dp_aux_pkg::hpd_state_t state;
    logic [CNT_W-1:0]       dur_cnt;
    logic [1:0]             hpd_sync;
    logic                   hpd;

    // raw line is asynchronous to clk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hpd_sync <= 2'b00;
        end else begin
            hpd_sync <= {hpd_sync[0], hpd_signal};
        end
    end

    assign hpd = hpd_sync[1];

    assign hpd_detect = (state == dp_aux_pkg::HPD_CONNECTED) ||
                        (state == dp_aux_pkg::HPD_LOW_PULSE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= dp_aux_pkg::HPD_DISCONNECTED;
            dur_cnt <= '0;
            hpd_irq <= 1'b0;
        end else begin
            hpd_irq <= 1'b0;
            case (state)
                dp_aux_pkg::HPD_DISCONNECTED: begin
                    dur_cnt <= CNT_W'(1);
                    if (hpd) begin
                        state <= dp_aux_pkg::HPD_CONNECTING;
                    end
                end
                dp_aux_pkg::HPD_CONNECTING: begin
                    if (!hpd) begin
                        state <= dp_aux_pkg::HPD_DISCONNECTED;
                    end else if (dur_cnt == CONNECT_LAST) begin
                        state <= dp_aux_pkg::HPD_CONNECTED;
                    end else begin
                        dur_cnt <= dur_cnt + 1'b1;
                    end
                end
                dp_aux_pkg::HPD_CONNECTED: begin
                    dur_cnt <= CNT_W'(1);
                    if (!hpd) begin
                        state <= dp_aux_pkg::HPD_LOW_PULSE;
                    end
                end
                dp_aux_pkg::HPD_LOW_PULSE: begin
                    if (hpd) begin
                        // short glitches below the minimum are ignored
                        hpd_irq <= (dur_cnt >= IRQ_MIN);
                        state   <= dp_aux_pkg::HPD_CONNECTED;
                    end else if (dur_cnt == IRQ_MAX) begin
                        // low for too long, sink unplugged
                        state <= dp_aux_pkg::HPD_DISCONNECTED;
                    end else begin
                        dur_cnt <= dur_cnt + 1'b1;
                    end
                end
                default: state <= dp_aux_pkg::HPD_DISCONNECTED;
            endcase
        end
    end

endmodule

//--- rtl/aux_ctrl_unit.sv
`include "dp_aux_defs.svh"

module aux_ctrl_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     spm_transaction_vld,
    input  dp_aux_pkg::aux_request_t spm_request,
    input  logic                     frame_done,
    input  dp_aux_pkg::aux_reply_t   reply,
    input  logic                     reply_start,
    input  logic                     reply_end,
    output logic                     start,
    output dp_aux_pkg::aux_request_t request,
    output logic                     spm_busy,
    output logic                     timer_timeout,
    output logic                     ctrl_native_failed
);

    localparam int TMR_W = $clog2(`DP_AUX_TIMEOUT_CYCLES);
    localparam int RTY_W = $clog2(`DP_AUX_MAX_RETRIES + 1);

    localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(`DP_AUX_TIMEOUT_CYCLES - 1);
    localparam logic [RTY_W-1:0] RTY_LAST = RTY_W'(`DP_AUX_MAX_RETRIES);

    dp_aux_pkg::ctrl_state_t state;
    dp_aux_pkg::ctrl_state_t state_nxt;
    logic [TMR_W-1:0]        timer;
    logic [RTY_W-1:0]        retry_cnt;
    logic [RTY_W-1:0]        retry_cnt_nxt;
    logic                    accept;
    logic                    timeout_hit;
    logic                    retry_now;
    logic                    start_nxt;
    logic                    failed_nxt;

    assign accept      = (state == dp_aux_pkg::CTRL_IDLE) && spm_transaction_vld;
    assign timeout_hit = (state == dp_aux_pkg::CTRL_WAIT_REPLY) && !reply_start &&
                         (timer == TMR_LAST);
    assign spm_busy    = (state != dp_aux_pkg::CTRL_IDLE);

    // ==================================================
    // next state
    // ==================================================
    always_comb begin
        state_nxt     = state;
        retry_cnt_nxt = retry_cnt;
        start_nxt     = 1'b0;
        failed_nxt    = 1'b0;
        retry_now     = 1'b0;
        case (state)
            dp_aux_pkg::CTRL_IDLE: begin
                if (accept) begin
                    state_nxt     = dp_aux_pkg::CTRL_SEND;
                    retry_cnt_nxt = '0;
                    start_nxt     = 1'b1;
                end
            end
            dp_aux_pkg::CTRL_SEND: begin
                if (frame_done) begin
                    state_nxt = dp_aux_pkg::CTRL_WAIT_REPLY;
                end
            end
            dp_aux_pkg::CTRL_WAIT_REPLY: begin
                if (reply_start) begin
                    state_nxt = dp_aux_pkg::CTRL_RECEIVE;
                end else if (timeout_hit) begin
                    retry_now = 1'b1;
                end
            end
            dp_aux_pkg::CTRL_RECEIVE: begin
                if (reply_end) begin
                    case (reply.ack)
                        `DP_AUX_ACK, `DP_AUX_NACK: state_nxt = dp_aux_pkg::CTRL_IDLE;
                        `DP_AUX_DEFER:             retry_now = 1'b1;
                        // reserved code, nothing to wait for
                        default:                   state_nxt = dp_aux_pkg::CTRL_IDLE;
                    endcase
                end
            end
            default: state_nxt = dp_aux_pkg::CTRL_IDLE;
        endcase

        // resend the same frame or give up
        if (retry_now) begin
            if (retry_cnt == RTY_LAST) begin
                failed_nxt = 1'b1;
                state_nxt  = dp_aux_pkg::CTRL_IDLE;
            end else begin
                retry_cnt_nxt = retry_cnt + 1'b1;
                start_nxt     = 1'b1;
                state_nxt     = dp_aux_pkg::CTRL_SEND;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state              <= dp_aux_pkg::CTRL_IDLE;
            retry_cnt          <= '0;
            timer              <= '0;
            start              <= 1'b0;
            timer_timeout      <= 1'b0;
            ctrl_native_failed <= 1'b0;
        end else begin
            state              <= state_nxt;
            retry_cnt          <= retry_cnt_nxt;
            start              <= start_nxt;
            timer_timeout      <= timeout_hit;
            ctrl_native_failed <= failed_nxt;
            // reply timer only runs while waiting
            if (state == dp_aux_pkg::CTRL_WAIT_REPLY) begin
                timer <= timer + 1'b1;
            end else begin
                timer <= '0;
            end
        end
    end

    // held for the encoder across retries
    always_ff @(posedge clk) begin
        if (accept) begin
            request <= spm_request;
        end
    end

endmodule

//--- rtl/native_message_encoder.sv
`include "dp_aux_defs.svh"

module native_message_encoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  dp_aux_pkg::aux_request_t request,
    output dp_aux_pkg::aux_byte_t    aux_out,
    output logic                     aux_out_vld,
    output logic                     aux_start_stop,
    output logic                     frame_done
);

    localparam dp_aux_pkg::aux_cmd_t CMD_READ    = dp_aux_pkg::aux_cmd_t'(1);
    localparam logic [1:0]           HEADER_LAST = 2'd3;

    dp_aux_pkg::enc_state_t state;
    logic [1:0]             byte_cnt;
    logic                   is_read;
    logic [3:0]             req_code;
    dp_aux_pkg::aux_len_t   len_byte;
    logic                   first_byte;
    logic                   last_byte;

    assign is_read  = (request.cmd == CMD_READ);
    assign req_code = is_read ? `DP_AUX_NATIVE_RD : `DP_AUX_NATIVE_WR;
    // length field is len - 1, a one-byte write sends zero
    assign len_byte = is_read ? request.len - 1'b1 : '0;

    assign first_byte = (state == dp_aux_pkg::ENC_HEADER) && (byte_cnt == 2'd0);
    assign last_byte  = (state == dp_aux_pkg::ENC_DATA) ||
                        ((state == dp_aux_pkg::ENC_HEADER) && (byte_cnt == HEADER_LAST) &&
                         is_read);

    assign aux_out_vld    = (state != dp_aux_pkg::ENC_IDLE);
    assign aux_start_stop = first_byte || last_byte;
    assign frame_done     = last_byte;

    // ==================================================
    // byte select
    // ==================================================
    always_comb begin
        aux_out = '0;
        if (state == dp_aux_pkg::ENC_HEADER) begin
            case (byte_cnt)
                2'd0:    aux_out = {req_code, request.address[`DP_AUX_ADDR_W-1 -: 4]};
                2'd1:    aux_out = request.address[15:8];
                2'd2:    aux_out = request.address[7:0];
                default: aux_out = len_byte;
            endcase
        end else if (state == dp_aux_pkg::ENC_DATA) begin
            aux_out = request.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= dp_aux_pkg::ENC_IDLE;
            byte_cnt <= 2'd0;
        end else begin
            case (state)
                dp_aux_pkg::ENC_IDLE: begin
                    byte_cnt <= 2'd0;
                    if (start) begin
                        state <= dp_aux_pkg::ENC_HEADER;
                    end
                end
                dp_aux_pkg::ENC_HEADER: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == HEADER_LAST) begin
                        state <= is_read ? dp_aux_pkg::ENC_IDLE : dp_aux_pkg::ENC_DATA;
                    end
                end
                dp_aux_pkg::ENC_DATA: state <= dp_aux_pkg::ENC_IDLE;
                default:              state <= dp_aux_pkg::ENC_IDLE;
            endcase
        end
    end

endmodule

//--- rtl/dp_source.sv
module dp_source (
    input  logic                     clk,
    input  logic                     rst_n,
    // requester side
    input  logic                     spm_transaction_vld,
    input  dp_aux_pkg::aux_request_t spm_request,
    output dp_aux_pkg::aux_reply_t   spm_reply,
    output logic                     spm_busy,
    output logic                     timer_timeout,
    output logic                     ctrl_native_failed,
    // aux byte buses
    input  dp_aux_pkg::aux_byte_t    aux_in,
    input  logic                     aux_in_vld,
    input  logic                     phy_start_stop,
    output dp_aux_pkg::aux_byte_t    aux_out,
    output logic                     aux_out_vld,
    output logic                     aux_start_stop,
    // hot plug
    input  logic                     hpd_signal,
    output logic                     hpd_detect,
    output logic                     hpd_irq
);

    // ==================================================
    // internal links
    // ==================================================
    logic                     start;
    logic                     frame_done;
    logic                     reply_start;
    logic                     reply_end;
    dp_aux_pkg::aux_request_t request;
    dp_aux_pkg::aux_reply_t   reply;

    assign spm_reply = reply;

    reply_decoder reply_decoder_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .aux_in         (aux_in),
        .aux_in_vld     (aux_in_vld),
        .phy_start_stop (phy_start_stop),
        .reply          (reply),
        .reply_start    (reply_start),
        .reply_end      (reply_end)
    );

    aux_ctrl_unit aux_ctrl_unit_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .spm_transaction_vld (spm_transaction_vld),
        .spm_request         (spm_request),
        .frame_done          (frame_done),
        .reply               (reply),
        .reply_start         (reply_start),
        .reply_end           (reply_end),
        .start               (start),
        .request             (request),
        .spm_busy            (spm_busy),
        .timer_timeout       (timer_timeout),
        .ctrl_native_failed  (ctrl_native_failed)
    );

    native_message_encoder native_message_encoder_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .request        (request),
        .aux_out        (aux_out),
        .aux_out_vld    (aux_out_vld),
        .aux_start_stop (aux_start_stop),
        .frame_done     (frame_done)
    );

    hpd_detector hpd_detector_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .hpd_signal (hpd_signal),
        .hpd_detect (hpd_detect),
        .hpd_irq    (hpd_irq)
    );

endmodule

//--- verif/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- verif/dp_source_checker.sv
module dp_source_checker (
    input logic clk,
    input logic rst_n,
    input logic aux_out_vld,
    input logic aux_start_stop,
    input logic spm_busy,
    input logic timer_timeout,
    input logic ctrl_native_failed,
    input logic hpd_irq
);

    timeunit 1ns;
    timeprecision 1ps;

    // frame starts right after busy rises
    first_byte_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(spm_busy) |=> aux_out_vld && aux_start_stop)
        else $error("first request byte missing one cycle after spm_busy rose");

    // the encoder only runs inside a transaction
    out_within_busy: assert property (@(posedge clk) disable iff (!rst_n)
        aux_out_vld |-> spm_busy)
        else $error("request byte sent while spm_busy is low");

    timeout_single: assert property (@(posedge clk) disable iff (!rst_n)
        timer_timeout |=> !timer_timeout)
        else $error("timer_timeout longer than one cycle");

    // failure only after a finished frame, never mid-frame
    failed_after_wait: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_native_failed |-> $past(spm_busy) && !$past(aux_out_vld))
        else $error("ctrl_native_failed outside a waiting transaction");

    irq_single: assert property (@(posedge clk) disable iff (!rst_n)
        hpd_irq |=> !hpd_irq)
        else $error("hpd_irq longer than one cycle");

endmodule

bind dp_source dp_source_checker dp_source_checker_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .aux_out_vld        (aux_out_vld),
    .aux_start_stop     (aux_start_stop),
    .spm_busy           (spm_busy),
    .timer_timeout      (timer_timeout),
    .ctrl_native_failed (ctrl_native_failed),
    .hpd_irq            (hpd_irq)
);

//--- verif/dp_source_tb.sv
`include "dp_aux_defs.svh"

module dp_source_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS   = 8;
    localparam int MAX_TRIES  = `DP_AUX_MAX_RETRIES + 1;
    localparam int HPD_CYCLES = 150;

    typedef struct packed {
        logic [1:0]  cmd;
        logic [19:0] addr;
        logic [7:0]  len;
        logic [7:0]  data;
        logic [3:0]  defers;
        logic [3:0]  silent;
        logic [1:0]  final_code;
        logic        fail;
    } test_row_t;

    logic                     clk;
    logic                     rst_n;
    logic                     spm_transaction_vld;
    dp_aux_pkg::aux_request_t spm_request;
    dp_aux_pkg::aux_reply_t   spm_reply;
    logic                     spm_busy;
    logic                     timer_timeout;
    logic                     ctrl_native_failed;
    dp_aux_pkg::aux_byte_t    aux_in;
    logic                     aux_in_vld;
    logic                     phy_start_stop;
    dp_aux_pkg::aux_byte_t    aux_out;
    logic                     aux_out_vld;
    logic                     aux_start_stop;
    logic                     hpd_signal;
    logic                     hpd_detect;
    logic                     hpd_irq;

    test_row_t  rows [NUM_ROWS];
    logic [7:0] exp_frame [$];
    logic [7:0] rx_frame [$];
    logic [7:0] exp_data [$];
    logic [7:0] rx_data [$];
    logic [8:0] tx_q [$];
    logic [31:0] sink_lcg;
    logic [31:0] exp_lcg;
    logic [1:0]  last_ack;
    logic [8:0]  tx_word;
    int tx_delay;
    int defer_left;
    int silent_left;
    int frame_cnt;
    int timeout_cnt;
    int failed_cnt;
    int irq_cnt;
    int errors;
    int pass_tests;
    int fail_tests;
    int cycle_cnt;
    int cycle_limit;
    test_row_t cur;

    tb_clock_gen #(.PERIOD_NS(20)) tb_clock_gen_i (.clk(clk));

    dp_source dp_source_i (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // ==================================================
    // sink model
    // ==================================================
    always @(negedge clk) begin
        if (tx_delay > 0) begin
            tx_delay--;
            aux_in_vld     = 1'b0;
            phy_start_stop = 1'b0;
        end else if (tx_q.size() > 0) begin
            tx_word        = tx_q.pop_front();
            aux_in         = tx_word[7:0];
            phy_start_stop = tx_word[8];
            aux_in_vld     = 1'b1;
        end else begin
            aux_in_vld     = 1'b0;
            phy_start_stop = 1'b0;
        end
        if (rst_n && aux_out_vld) begin
            assert (rx_frame.size() < exp_frame.size()) else begin
                $display("request frame longer than %0d bytes", exp_frame.size());
                errors++;
            end
            if (rx_frame.size() < exp_frame.size()) begin
                check_value("aux_out", int'(aux_out), int'(exp_frame[rx_frame.size()]));
                check_value("aux_start_stop", int'(aux_start_stop),
                            int'(rx_frame.size() == 0 ||
                                 rx_frame.size() == exp_frame.size() - 1));
            end
            rx_frame.push_back(aux_out);
            if (aux_start_stop && rx_frame.size() > 1) begin
                check_value("frame length", rx_frame.size(), exp_frame.size());
                rx_frame.delete();
                frame_cnt++;
                tx_delay = 3;
                if (silent_left > 0) begin
                    silent_left--;
                end else if (defer_left > 0) begin
                    defer_left--;
                    tx_q.push_back({1'b1, 2'b00, `DP_AUX_DEFER, 4'h0});
                end else begin
                    tx_q.push_back({1'b1, 2'b00, cur.final_code, 4'h0});
                    if (cur.cmd == 2'd1 && cur.final_code == `DP_AUX_ACK) begin
                        for (int k = 0; k < int'(cur.len); k++) begin
                            sink_lcg = lcg_next(sink_lcg);
                            tx_q.push_back({k == int'(cur.len) - 1, sink_lcg[23:16]});
                        end
                    end
                end
            end
        end
    end

    // reply and pulse monitor
    always @(negedge clk) begin
        if (rst_n) begin
            if (timer_timeout) timeout_cnt++;
            if (ctrl_native_failed) failed_cnt++;
            if (hpd_irq) irq_cnt++;
            if (spm_reply.ack_vld) last_ack = spm_reply.ack;
            if (spm_reply.data_vld) rx_data.push_back(spm_reply.data);
        end
    end

    always @(negedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("run stopped after %0d cycles without finishing", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    task automatic run_row(input int n);
        int err_before;
        int attempts;
        int frames0;
        int timeouts0;
        int failed0;
        err_before = errors;
        cur        = rows[n];
        attempts   = int'(cur.defers) + int'(cur.silent) + 1;
        if (attempts > MAX_TRIES) attempts = MAX_TRIES;
        exp_frame.delete();
        exp_frame.push_back({(cur.cmd == 2'd1) ? `DP_AUX_NATIVE_RD : `DP_AUX_NATIVE_WR,
                             cur.addr[19:16]});
        exp_frame.push_back(cur.addr[15:8]);
        exp_frame.push_back(cur.addr[7:0]);
        exp_frame.push_back((cur.cmd == 2'd1) ? cur.len - 8'd1 : 8'd0);
        if (cur.cmd == 2'd0) exp_frame.push_back(cur.data);
        exp_data.delete();
        rx_data.delete();
        if (cur.cmd == 2'd1 && cur.final_code == `DP_AUX_ACK && !cur.fail) begin
            for (int k = 0; k < int'(cur.len); k++) begin
                exp_lcg = lcg_next(exp_lcg);
                exp_data.push_back(exp_lcg[23:16]);
            end
        end
        defer_left  = int'(cur.defers);
        silent_left = int'(cur.silent);
        frames0     = frame_cnt;
        timeouts0   = timeout_cnt;
        failed0     = failed_cnt;
        // reserved code until this row's reply arrives
        last_ack    = 2'b11;
        spm_request = '{cmd: cur.cmd, address: cur.addr, len: cur.len, data: cur.data};
        spm_transaction_vld = 1'b1;
        @(negedge clk);
        spm_transaction_vld = 1'b0;
        while (!spm_busy) @(negedge clk);
        // strobe while busy must be dropped
        spm_request.address = ~cur.addr;
        spm_transaction_vld = 1'b1;
        @(negedge clk);
        spm_transaction_vld = 1'b0;
        while (spm_busy) @(negedge clk);
        repeat (3) @(negedge clk);
        check_value("frame count", frame_cnt - frames0, attempts);
        check_value("ctrl_native_failed pulses", failed_cnt - failed0, int'(cur.fail));
        check_value("timer_timeout pulses", timeout_cnt - timeouts0,
                    (int'(cur.silent) < attempts) ? int'(cur.silent) : attempts);
        if (!cur.fail) check_value("spm_reply.ack", int'(last_ack), int'(cur.final_code));
        check_value("reply data count", rx_data.size(), exp_data.size());
        for (int k = 0; k < exp_data.size() && k < rx_data.size(); k++) begin
            check_value("spm_reply.data", int'(rx_data[k]), int'(exp_data[k]));
        end
        if (errors == err_before) begin
            pass_tests++;
            $display("row %0d: ok", n);
        end else begin
            fail_tests++;
            $display("row %0d: %0d errors", n, errors - err_before);
        end
    endtask

    task automatic hpd_phase();
        int err_before;
        int irq0;
        err_before = errors;
        hpd_signal = 1'b1;
        repeat (30) @(negedge clk);
        check_value("hpd_detect", int'(hpd_detect), 1);
        irq0 = irq_cnt;
        hpd_signal = 1'b0;
        repeat (8) @(negedge clk);
        hpd_signal = 1'b1;
        repeat (12) @(negedge clk);
        check_value("hpd_irq pulses", irq_cnt - irq0, 1);
        check_value("hpd_detect", int'(hpd_detect), 1);
        irq0 = irq_cnt;
        hpd_signal = 1'b0;
        repeat (30) @(negedge clk);
        check_value("hpd_detect", int'(hpd_detect), 0);
        check_value("hpd_irq pulses", irq_cnt - irq0, 0);
        if (errors == err_before) begin
            pass_tests++;
            $display("hpd: ok");
        end else begin
            fail_tests++;
            $display("hpd: %0d errors", errors - err_before);
        end
    endtask

    initial begin
        int tries;
        int flen;
        int rlen;
        rst_n               = 1'b0;
        spm_transaction_vld = 1'b0;
        spm_request         = '0;
        aux_in              = '0;
        aux_in_vld          = 1'b0;
        phy_start_stop      = 1'b0;
        hpd_signal          = 1'b0;
        sink_lcg            = 32'h87871635;
        exp_lcg             = 32'h87871635;
        // cmd, address, len, data, defers, silent, final code, fail
        rows[0] = '{2'd0, 20'h00100, 8'd1, 8'hA5, 4'd0, 4'd0, `DP_AUX_ACK,  1'b0};
        rows[1] = '{2'd1, 20'h00202, 8'd4, 8'h00, 4'd0, 4'd0, `DP_AUX_ACK,  1'b0};
        rows[2] = '{2'd1, 20'h12345, 8'd2, 8'h00, 4'd0, 4'd0, `DP_AUX_NACK, 1'b0};
        rows[3] = '{2'd0, 20'hABCDE, 8'd1, 8'h3C, 4'd0, 4'd0, `DP_AUX_NACK, 1'b0};
        rows[4] = '{2'd1, 20'h00010, 8'd3, 8'h00, 4'd1, 4'd0, `DP_AUX_ACK,  1'b0};
        rows[5] = '{2'd0, 20'h00600, 8'd1, 8'h5A, 4'd4, 4'd0, `DP_AUX_ACK,  1'b1};
        rows[6] = '{2'd1, 20'h00700, 8'd1, 8'h00, 4'd0, 4'd4, `DP_AUX_ACK,  1'b1};
        rows[7] = '{2'd0, 20'h00800, 8'd1, 8'h77, 4'd0, 4'd1, `DP_AUX_ACK,  1'b0};
        cycle_limit = HPD_CYCLES + 200;
        for (int n = 0; n < NUM_ROWS; n++) begin
            tries = int'(rows[n].defers) + int'(rows[n].silent) + 1;
            if (tries > MAX_TRIES) tries = MAX_TRIES;
            flen = (rows[n].cmd == 2'd1) ? 4 : 5;
            rlen = (rows[n].cmd == 2'd1) ? 1 + int'(rows[n].len) : 1;
            cycle_limit += tries * (flen + `DP_AUX_TIMEOUT_CYCLES + rlen + 10);
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        for (int n = 0; n < NUM_ROWS; n++) begin
            run_row(n);
        end
        hpd_phase();
        $display("tests: %0d passed, %0d failed", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+rtl
rtl/dp_aux_pkg.sv
rtl/reply_decoder.sv
rtl/hpd_detector.sv
rtl/aux_ctrl_unit.sv
rtl/native_message_encoder.sv
rtl/dp_source.sv
verif/tb_clock_gen.sv
verif/dp_source_checker.sv
verif/dp_source_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= dp_source_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
